//--- build.f
+incdir+verilog
+incdir+verif
verilog/heapPkg.sv
verilog/heapCheckStage.sv
verilog/heapElementStage.sv
verilog/heapTop.sv
verif/heapTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
verilator --binary --timing --assert -f build.f --top-module heapTb -o heapSim > build.log 2>&1 \
  || { cat build.log; echo 'Build failed'; exit 1; }
./obj_dir/heapSim > sim.log 2>&1
cat sim.log
grep -q 'Test failures found' sim.log && exit 1
grep -q 'All tests passed!' sim.log || exit 1
exit 0

//--- verif/heapTable.svh
//--------------------------------------
// Stimulus rows for the heap testbench, each with its expected answer.
// Included inside the testbench module, filled once at time zero.
//--------------------------------------
`ifndef HEAP_TABLE_SVH
`define HEAP_TABLE_SVH

typedef struct packed {
  heapAction                 action;
  logic [`heapArrayBits-1:0] array;
  logic [`heapIndexBits-1:0] index;
  logic [`heapDataBits-1:0]  data;
  logic [`heapDataBits-1:0]  expData;              // Expected answer
  heapError                  expError;
} tableRow;

localparam int maxRows = 64;
localparam logic [`heapDataBits-1:0] noData = '0;  // Answer of any failed check

tableRow                  rows [maxRows];
int                       rowCount;
logic [`heapDataBits-1:0] values [16];             // Random operands

function automatic void addRow(input heapAction action, input int array, input int index,
                               input logic [`heapDataBits-1:0] data,
                               input logic [`heapDataBits-1:0] expData,
                               input heapError expError);
  rows[rowCount].action   = action;
  rows[rowCount].array    = array[`heapArrayBits-1:0];
  rows[rowCount].index    = index[`heapIndexBits-1:0];
  rows[rowCount].data     = data;
  rows[rowCount].expData  = expData;
  rows[rowCount].expError = expError;
  rowCount++;
endfunction

function automatic void buildTable();
  logic [31:0]              raw;
  logic [`heapDataBits-1:0] sumOne;                // After Add
  logic [`heapDataBits-1:0] sumTwo;                // After AddAfter
  for (int k = 0; k < 16; k++) begin
    raw       = $urandom;
    values[k] = raw[`heapDataBits-1:0];
  end
  sumOne   = values[0] + values[10];
  sumTwo   = sumOne + values[11];
  rowCount = 0;
  // ---------- allocation and element access
  addRow(actionRead,  0, 0, noData, noData, notAllocated);
  addRow(actionAlloc, 0, 0, noData, 16'd0, none);
  addRow(actionAlloc, 0, 0, noData, 16'd1, none);
  addRow(actionWrite, 0, 2, values[0], values[0], none);
  addRow(actionSize,  0, 0, noData, 16'd3, none);  // Grown to index plus one
  addRow(actionRead,  0, 2, noData, values[0], none);
  addRow(actionRead,  0, 5, values[15], noData, outOfBounds);
  // ---------- stack use on array 1
  for (int k = 0; k < 8; k++) addRow(actionPush, 1, 0, values[k+1], values[k+1], none);
  addRow(actionPush, 1, 0, values[9], noData, arrayFull);
  for (int k = 0; k < 8; k++) addRow(actionPop, 1, 0, noData, values[8-k], none);
  addRow(actionPop, 1, 0, noData, noData, arrayEmpty);
  // ---------- read-modify-write on element 2 of array 0
  addRow(actionAdd,      0, 2, values[10], sumOne, none);
  addRow(actionAddAfter, 0, 2, values[11], sumOne, none);  // Old value back
  addRow(actionRead,     0, 2, noData, sumTwo, none);
  addRow(actionXor,      0, 2, values[12], sumTwo ^ values[12], none);
  addRow(actionRead,     0, 2, noData, sumTwo ^ values[12], none);
  // ---------- free, reuse and exhaustion
  addRow(actionFree,  1, 0, noData, noData, none);
  addRow(actionRead,  1, 0, noData, noData, arrayFreed);
  addRow(actionFree,  1, 0, noData, noData, arrayFreed);   // Double free
  addRow(actionAlloc, 0, 0, noData, 16'd1, none);          // Reuses array 1
  for (int k = 2; k < 8; k++) addRow(actionAlloc, 0, 0, noData, k[`heapDataBits-1:0], none);
  addRow(actionAlloc, 0, 0, noData, noData, outOfMemory);
  // ---------- back to back on array 3, then Reset
  addRow(actionWrite, 3, 0, values[13], values[13], none);
  addRow(actionRead,  3, 0, noData, values[13], none);
  addRow(actionWrite, 3, 7, values[14], values[14], none);
  addRow(actionSize,  3, 0, noData, 16'd8, none);
  addRow(actionReset, 0, 0, noData, noData, none);
  for (int k = 0; k < 8; k++) addRow(actionRead, k, 0, noData, noData, notAllocated);
  addRow(actionAlloc, 0, 0, noData, 16'd0, none);          // Counting restarts
endfunction

`endif

//--- verif/heapTb.sv
//--------------------------------------
// Testbench for the array heap. Issues the table rows back to back and
// checks each response as its done pulse arrives.
//--------------------------------------
`include "heapDefs_defs.svh"

module heapTb
  import heapPkg::*;
();

  logic        clock;
  logic        resetN;
  logic        start;
  heapRequest  request;
  heapResponse response;
  logic        done;

  `include "heapTable.svh"

  localparam int doneLimit = 20;                   // Cycles allowed per answer
  localparam int latency   = 2;                    // Clocks from drive to answer

  int cycle;                                       // Rising edges so far
  int issueCycle [maxRows];                        // Cycle each row was driven

  heapTop heapTop_inst (
    .clock    (clock),
    .resetN   (resetN),
    .start    (start),
    .request  (request),
    .response (response),
    .done     (done)
  );

  always #5 clock = ~clock;

  always @(posedge clock) cycle++;

  task automatic stopRun();
    $display("Test failures found");
    $fatal(1, "Stopping at the first failed check");
  endtask

  // One row per clock, then idle
  task automatic issueRows();
    for (int r = 0; r < rowCount; r++) begin
      @(posedge clock);
      #1;
      start          = 1'b1;
      request.action = rows[r].action;
      request.array  = rows[r].array;
      request.index  = rows[r].index;
      request.data   = rows[r].data;
      issueCycle[r]  = cycle;
    end
    @(posedge clock);
    #1;
    start   = 1'b0;
    request = '0;
  endtask

  // Sampled at the falling edge, away from the register update
  task automatic waitForDone(input int row);
    int waited;
    waited = 0;
    @(negedge clock);
    while (!done && waited < doneLimit) begin
      @(negedge clock);
      waited++;
    end
    assert (done) else begin
      $display("No done pulse within %0d cycles for row %0d", doneLimit, row);
      stopRun();
    end
  endtask

  task automatic checkResponses();
    for (int r = 0; r < rowCount; r++) begin
      waitForDone(r);
      assert (cycle == issueCycle[r] + latency) else begin
        $display("Mismatch at %0t: row %0d answered after %0d cycles, expected %0d",
                 $time, r, cycle - issueCycle[r], latency);
        stopRun();
      end
      assert (response.error == rows[r].expError) else begin
        $display("Mismatch at %0t: row %0d error code %0d, expected %0d", $time, r,
                 response.error, rows[r].expError);
        stopRun();
      end
      assert (response.data == rows[r].expData) else begin
        $display("Mismatch at %0t: row %0d data %h, expected %h", $time, r,
                 response.data, rows[r].expData);
        stopRun();
      end
    end
  endtask

  // Whole run bound
  initial begin
    #20000;
    $display("Run did not finish in time");
    $display("Test failures found");
    $fatal(1, "Simulation time limit reached");
  end

  initial begin
    int strayDone;
    clock     = 1'b0;
    resetN    = 1'b0;
    start     = 1'b0;
    request   = '0;
    cycle     = 0;
    strayDone = 0;
    void'($urandom(44));
    buildTable();
    repeat (10) @(posedge clock);                  // Reset held 10 cycles
    #1;
    resetN = 1'b1;
    fork
      issueRows();
      checkResponses();
    join
    repeat (5) begin                               // No answers past the table
      @(negedge clock);
      if (done) strayDone++;
    end
    if (strayDone == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Done pulsed %0d times after the last request", strayDone);
      $display("Test failures found");
      $fatal(1, "Unexpected done pulse");
    end
  end

endmodule

//--- verilog/heapCheckStage.sv
//--------------------------------------
// Stage one of the heap. Owns allocation, sizes and the freed stack,
// checks each request and hands element work to stage two.
//--------------------------------------
`include "heapDefs_defs.svh"

module heapCheckStage
  import heapPkg::*;
(
  input  logic          clock,
  input  logic          resetN,
  input  logic          start,                     // Request strobe
  input  heapRequest    request,
  output elementCommand command                    // To element stage
);

  localparam int padSize  = `heapDataBits - `heapIndexBits - 1;
  localparam int padArray = `heapDataBits - `heapArrayBits;

  //--------------------------------------
  // Bookkeeping state
  //--------------------------------------
  logic [`heapArrays-1:0]    allocated;            // One flag per array
  logic [`heapIndexBits:0]   sizes [`heapArrays];  // Current length per array
  logic [`heapArrayBits-1:0] freedStack [`heapArrays];
  logic [`heapArrayBits:0]   freedTop;             // Entries on freed stack
  logic [`heapArrayBits:0]   newCount;             // Arrays ever handed out

  logic [`heapIndexBits:0]   sizeNow;              // Size of addressed array
  logic [`heapIndexBits:0]   sizeLess;             // Size after a pop
  logic [`heapArrayBits-1:0] popSlot;              // Top entry of freed stack
  logic [`heapArrayBits-1:0] pushSlot;             // Next free stack entry
  logic [`heapArrayBits-1:0] allocArray;           // Array Alloc would return
  logic                      needsBounds;          // Index must be inside size
  heapError                  checkError;
  logic                      accept;               // Request passes all checks
  elementCommand             nextCommand;

  assign sizeNow    = sizes[request.array];
  assign sizeLess   = sizeNow - 1'b1;
  assign popSlot    = freedTop[`heapArrayBits-1:0] - 1'b1;
  assign pushSlot   = freedTop[`heapArrayBits-1:0];
  assign allocArray = (freedTop != '0) ? freedStack[popSlot]
                                       : newCount[`heapArrayBits-1:0];
  assign needsBounds = request.action inside {actionRead, actionAdd,
                                              actionAddAfter, actionXor};
  assign accept = start && (checkError == none);

  //--------------------------------------
  // Error rules, first match wins
  //--------------------------------------
  always_comb begin
    checkError = none;
    case (request.action)
      actionAlloc: begin
        if (freedTop == '0 && newCount == `heapArrays) begin
          checkError = outOfMemory;                // Nothing freed, all used
        end
      end
      actionWrite, actionRead, actionSize, actionPush, actionPop,
      actionFree, actionAdd, actionAddAfter, actionXor: begin
        if ({1'b0, request.array} >= newCount) begin
          checkError = notAllocated;
        end else if (!allocated[request.array]) begin
          checkError = arrayFreed;                 // Also a double free
        end else if (needsBounds && {1'b0, request.index} >= sizeNow) begin
          checkError = outOfBounds;
        end else if (request.action == actionPop && sizeNow == '0) begin
          checkError = arrayEmpty;
        end else if (request.action == actionPush && sizeNow == `heapArrayLength) begin
          checkError = arrayFull;
        end
      end
      default: checkError = none;                  // Idle, Reset, unknown
    endcase
  end

  //--------------------------------------
  // Command for stage two
  //--------------------------------------
  always_comb begin
    nextCommand             = '0;
    nextCommand.valid       = 1'b1;
    nextCommand.op          = idle;
    nextCommand.array       = request.array;
    nextCommand.index       = request.index;
    nextCommand.data        = request.data;
    nextCommand.error       = checkError;
    if (checkError == none) begin
      case (request.action)
        actionWrite:    nextCommand.op = write;
        actionRead:     nextCommand.op = read;
        actionAdd:      nextCommand.op = add;
        actionAddAfter: nextCommand.op = addAfter;
        actionXor:      nextCommand.op = xorOp;
        actionPush: begin                          // Append at old size
          nextCommand.op     = write;
          nextCommand.index  = sizeNow[`heapIndexBits-1:0];
        end
        actionPop: begin                           // Read last element
          nextCommand.op     = read;
          nextCommand.index  = sizeLess[`heapIndexBits-1:0];
        end
        actionSize:  nextCommand.directValue = {{padSize{1'b0}}, sizeNow};
        actionAlloc: nextCommand.directValue = {{padArray{1'b0}}, allocArray};
        default:     nextCommand.directValue = '0; // Free, Reset, idle
      endcase
    end
    nextCommand.direct      = (nextCommand.op == idle);  // Zero or bookkeeping answer
  end

  //--------------------------------------
  // Control state and command register
  //--------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      freedTop  <= '0;
      newCount  <= '0;
      command   <= '0;
    end else begin
      command <= start ? nextCommand : '0;
      if (accept) begin
        case (request.action)
          actionReset: begin                       // Forget every array
            allocated <= '0;
            freedTop  <= '0;
            newCount  <= '0;
          end
          actionAlloc: begin
            allocated[allocArray] <= 1'b1;
            if (freedTop != '0) freedTop <= freedTop - 1'b1;  // Reuse freed
            else                newCount <= newCount + 1'b1;  // Fresh array
          end
          actionFree: begin
            allocated[request.array] <= 1'b0;
            freedTop                 <= freedTop + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Per-array sizes and freed stack contents
  always_ff @(posedge clock) begin
    if (accept) begin
      case (request.action)
        actionWrite: begin
          if ({1'b0, request.index} >= sizeNow) begin
            sizes[request.array] <= {1'b0, request.index} + 1'b1;  // Grow
          end
        end
        actionPush:  sizes[request.array] <= sizeNow + 1'b1;
        actionPop:   sizes[request.array] <= sizeLess;
        actionAlloc: sizes[allocArray]    <= '0;    // New array is empty
        actionFree:  freedStack[pushSlot] <= request.array;
        default: ;
      endcase
    end
  end

  // Freed stack can never hold more than every array
  assert property (@(posedge clock) disable iff (!resetN) freedTop <= `heapArrays);

  // A successful Alloc hands out only an array nobody holds
  assert property (@(posedge clock) disable iff (!resetN)
    (accept && request.action == actionAlloc) |-> !allocated[allocArray]);

endmodule

//--- verilog/heapDefs_defs.svh
//--------------------------------------
// Sizing of the array heap: array count, array length and element width.
// Included by the package and by every RTL block that sizes storage.
//--------------------------------------
`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

`define heapArrayBits   3                          // Bits in an array number
`define heapIndexBits   3                          // Bits in an element index
`define heapDataBits    16                         // Width of one element

`define heapArrayLength (1 << `heapIndexBits)      // Elements per array
`define heapArrays      (1 << `heapArrayBits)      // Arrays in the heap

`endif

//--- verilog/heapElementStage.sv
//--------------------------------------
// Stage two of the heap. Holds the element words, does the read-modify-write
// for each command and registers the response with a one-cycle done.
//--------------------------------------
`include "heapDefs_defs.svh"

module heapElementStage
  import heapPkg::*;
(
  input  logic          clock,
  input  logic          resetN,
  input  elementCommand command,                   // From check stage
  output heapResponse   response,
  output logic          done                       // One pulse per request
);

  //--------------------------------------
  // Element storage
  //--------------------------------------
  logic [`heapDataBits-1:0] elements [`heapArrays][`heapArrayLength];

  logic [`heapDataBits-1:0] oldValue;              // Element before the op
  logic [`heapDataBits-1:0] sumValue;
  logic [`heapDataBits-1:0] xorValue;
  logic [`heapDataBits-1:0] storeValue;            // Element after the op
  logic [`heapDataBits-1:0] opResult;              // Answer from element work
  logic [`heapDataBits-1:0] answer;                // Direct or element answer
  logic                     writeEnable;

  assign oldValue = elements[command.array][command.index];
  assign sumValue = oldValue + command.data;
  assign xorValue = oldValue ^ command.data;

  always_comb begin
    storeValue  = oldValue;
    opResult    = '0;
    writeEnable = 1'b0;
    case (command.op)
      write: begin
        storeValue  = command.data;
        opResult    = command.data;                // Echo stored data
        writeEnable = 1'b1;
      end
      read: opResult = oldValue;
      add: begin
        storeValue  = sumValue;
        opResult    = sumValue;                    // New value
        writeEnable = 1'b1;
      end
      addAfter: begin
        storeValue  = sumValue;
        opResult    = oldValue;                    // Value before the add
        writeEnable = 1'b1;
      end
      xorOp: begin
        storeValue  = xorValue;
        opResult    = xorValue;
        writeEnable = 1'b1;
      end
      default: ;                                   // Idle
    endcase
  end

  assign answer = command.direct ? command.directValue : opResult;

  always_ff @(posedge clock) begin
    if (command.valid && writeEnable) begin
      elements[command.array][command.index] <= storeValue;
    end
  end

  //--------------------------------------
  // Response register
  //--------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      response <= '0;
      done     <= 1'b0;
    end else begin
      done <= command.valid;
      if (command.valid) begin
        response.data  <= answer;
        response.error <= command.error;
      end
    end
  end

  // A failed check in stage one must never reach the element words
  assert property (@(posedge clock) disable iff (!resetN)
    (command.valid && command.error != none) |-> command.op == idle);

endmodule

//--- verilog/heapPkg.sv
//--------------------------------------
// Types shared by the heap pipeline: action and error codes, the caller
// request, the stage one to stage two command, and the response.
//--------------------------------------
`include "heapDefs_defs.svh"

package heapPkg;

  typedef enum logic [7:0] {                       // Caller actions
    actionIdle     = 8'd0,                         // Nothing this cycle
    actionReset    = 8'd1,                         // Forget all arrays
    actionWrite    = 8'd2,
    actionRead     = 8'd3,
    actionSize     = 8'd4,
    actionPush     = 8'd14,
    actionPop      = 8'd15,
    actionAlloc    = 8'd18,
    actionFree     = 8'd19,
    actionAdd      = 8'd20,                        // Answers the new value
    actionAddAfter = 8'd21,                        // Answers the old value
    actionXor      = 8'd29
  } heapAction;

  typedef enum logic [3:0] {
    none,
    notAllocated,                                  // Array never handed out
    arrayFreed,                                    // Array handed out, now free
    outOfBounds,                                   // Index at or past size
    arrayEmpty,
    arrayFull,
    outOfMemory                                    // No array left to give
  } heapError;

  typedef struct packed {
    heapAction                   action;
    logic [`heapArrayBits-1:0]   array;
    logic [`heapIndexBits-1:0]   index;
    logic [`heapDataBits-1:0]    data;
  } heapRequest;

  typedef enum logic [2:0] {idle, write, read, add, addAfter, xorOp} elementOp;

  typedef struct packed {
    logic                        valid;            // One per request
    elementOp                    op;               // Element work, idle if none
    logic [`heapArrayBits-1:0]   array;
    logic [`heapIndexBits-1:0]   index;
    logic [`heapDataBits-1:0]    data;             // Operand
    heapError                    error;
    logic                        direct;           // Answer already known
    logic [`heapDataBits-1:0]    directValue;
  } elementCommand;

  typedef struct packed {
    logic [`heapDataBits-1:0]    data;
    heapError                    error;
  } heapResponse;

endpackage

//--- verilog/heapTop.sv
//--------------------------------------
// Heap of fixed-length arrays. Two-stage pipeline, answer two
// clocks after the start strobe, one request per clock.
//--------------------------------------
module heapTop
  import heapPkg::*;
(
  input  logic        clock,
  input  logic        resetN,
  input  logic        start,                       // One-cycle request strobe
  input  heapRequest  request,
  output heapResponse response,
  output logic        done                         // Pulses with the answer
);

  elementCommand command;                          // Stage one to stage two

  // Checks and bookkeeping
  heapCheckStage checkStage (
    .clock   (clock),
    .resetN  (resetN),
    .start   (start),
    .request (request),
    .command (command)
  );

  // Element storage and answer
  heapElementStage elementStage (
    .clock    (clock),
    .resetN   (resetN),
    .command  (command),
    .response (response),
    .done     (done)
  );

endmodule
